/* chart/chart_mem.sv */
`default_nettype none

`include "chart_defines.svh"

module chart_mem import chart_pkg::*; (
    input  logic        prog_clk,
    input  logic        rst,
    input  chart_wr_t   chart_wr,
    input  chart_addr_t rd_addr,
    output note_t       rd_note
);

    note_t mem [`CHART_LEN];

    always_ff @(posedge prog_clk) begin
        if (chart_wr.valid) begin
            mem[chart_wr.addr] <= chart_wr.note;
        end
    end

    // Read data lands one cycle after the address
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            rd_note <= '0;
        end else begin
            rd_note <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* chart/chart_sequencer.sv */
`default_nettype none

`include "chart_defines.svh"

module chart_sequencer import chart_pkg::*; (
    input  logic        prog_clk,
    input  logic        rst,
    input  logic        start,
    input  chart_len_t  chart_len,
    input  note_t       rd_note,
    output chart_addr_t rd_addr,
    output note_t       cur_note,
    output logic        scan,
    output led_t        led,
    output logic        playing,
    output logic        done,
    output chart_addr_t note_index
);

    localparam int CYC_W = $clog2(`STEP_CYCLES);

    play_state_e      state;
    logic [CYC_W-1:0] cyc_cnt;
    chart_addr_t      step_cnt;
    logic             step_end;
    logic             last_count;
    logic             last_note;

    assign step_end   = (cyc_cnt == CYC_W'(`STEP_CYCLES - 1));
    assign last_count = (step_cnt == chart_addr_t'(`COUNT_STEPS - 1));
    assign last_note  = ({1'b0, step_cnt} == chart_len - 1'b1);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            cyc_cnt  <= '0;
            step_cnt <= '0;
            rd_addr  <= '0;
            cur_note <= '0;
        end else begin
            cyc_cnt <= step_end ? '0 : cyc_cnt + 1'b1;
            case (state)
                IDLE, DONE: begin
                    cyc_cnt <= '0;
                    if (start) begin
                        state    <= COUNT;
                        step_cnt <= '0;
                        rd_addr  <= '0;
                    end
                end
                COUNT: begin
                    if (step_end && last_count) begin
                        step_cnt <= '0;
                        if (chart_len == '0) begin
                            state <= DONE;
                        end else begin
                            // First note was fetched during the countdown
                            state    <= PLAY;
                            cur_note <= rd_note;
                            rd_addr  <= rd_addr + 1'b1;
                        end
                    end else if (step_end) begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                PLAY: begin
                    if (step_end && last_note) begin
                        state    <= DONE;
                        cur_note <= '0;
                    end else if (step_end) begin
                        step_cnt <= step_cnt + 1'b1;
                        cur_note <= rd_note;
                        rd_addr  <= rd_addr + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Two scans per step
    assign scan = (state == PLAY) &&
                  (cyc_cnt == '0 || cyc_cnt == CYC_W'(`SCAN_CYCLES));

    assign playing    = (state == PLAY);
    assign done       = (state == DONE);
    assign note_index = playing ? step_cnt : '0;

    // C lights led[7], octave shift lights led[0]
    always_comb begin
        led[0] = (cur_note[8:7] == 2'b01) || (cur_note[8:7] == 2'b10);
        for (int i = 0; i < 7; i++) begin
            led[7-i] = cur_note[i];
        end
    end

endmodule

`default_nettype wire

/* common/chart_defines.svh */
`ifndef CHART_DEFINES_SVH
`define CHART_DEFINES_SVH

// Chart capacity and step timing in prog_clk cycles
`define CHART_LEN      64
`define STEP_CYCLES    16
`define SCAN_CYCLES    8
`define COUNT_STEPS    3

`define SCORE_W        14
`define PTS_PERFECT    10
`define PTS_GREAT      8
`define PTS_GOOD       5

// Half periods, middle octave
`define HP_MID_C       40
`define HP_MID_D       36
`define HP_MID_E       32
`define HP_MID_F       30
`define HP_MID_G       27
`define HP_MID_A       24
`define HP_MID_B       21

// Low octave is one octave down
`define HP_LOW_C       (`HP_MID_C * 2)
`define HP_LOW_D       (`HP_MID_D * 2)
`define HP_LOW_E       (`HP_MID_E * 2)
`define HP_LOW_F       (`HP_MID_F * 2)
`define HP_LOW_G       (`HP_MID_G * 2)
`define HP_LOW_A       (`HP_MID_A * 2)
`define HP_LOW_B       (`HP_MID_B * 2)

`define HP_HIGH_C      (`HP_MID_C / 2)
`define HP_HIGH_D      (`HP_MID_D / 2)
`define HP_HIGH_E      (`HP_MID_E / 2)
`define HP_HIGH_F      (`HP_MID_F / 2)
`define HP_HIGH_G      (`HP_MID_G / 2)
`define HP_HIGH_A      (`HP_MID_A / 2)
`define HP_HIGH_B      (`HP_MID_B / 2)

`endif

/* common/chart_pkg.sv */
`default_nettype none

`include "chart_defines.svh"

package chart_pkg;

    // Top 2 bits octave (00 mid, 01 low, 10 high), low 7 bits one-hot C..B
    typedef logic [8:0] note_t;

    typedef logic [$clog2(`CHART_LEN)-1:0]   chart_addr_t;
    typedef logic [$clog2(`CHART_LEN+1)-1:0] chart_len_t;
    typedef logic [`SCORE_W-1:0]             score_t;
    typedef logic [7:0]                      led_t;
    typedef logic [15:0]                     half_period_t;

    typedef struct packed {
        logic        valid;
        chart_addr_t addr;
        note_t       note;
    } chart_wr_t;

    // prev1 is the most recent scan
    typedef struct packed {
        note_t prev1;
        note_t prev2;
        note_t prev3;
    } note_history_t;

    typedef enum logic [1:0] {
        IDLE,
        COUNT,
        PLAY,
        DONE
    } play_state_e;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+common
common/chart_pkg.sv
chart/chart_mem.sv
chart/chart_sequencer.sv
score/input_history.sv
score/score_judge.sv
hdl/tone_gen.sv
hdl/chart_player_top.sv
tests/tb_chart_player.sv

/* hdl/chart_player_top.sv */
`default_nettype none

module chart_player_top import chart_pkg::*; (
    input  logic        prog_clk,
    input  logic        rst,
    input  logic        start,
    input  chart_len_t  chart_len,
    input  chart_wr_t   chart_wr,
    input  note_t       user_in,
    output note_t       cur_note,
    output led_t        led,
    output logic        sig,
    output score_t      score,
    output logic        playing,
    output logic        done,
    output chart_addr_t note_index
);

    chart_addr_t   rd_addr;
    note_t         rd_note;
    logic          scan;
    note_history_t note_history;

    chart_mem u_chart_mem (
        .prog_clk (prog_clk),
        .rst      (rst),
        .chart_wr (chart_wr),
        .rd_addr  (rd_addr),
        .rd_note  (rd_note)
    );

    chart_sequencer u_chart_sequencer (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .start      (start),
        .chart_len  (chart_len),
        .rd_note    (rd_note),
        .rd_addr    (rd_addr),
        .cur_note   (cur_note),
        .scan       (scan),
        .led        (led),
        .playing    (playing),
        .done       (done),
        .note_index (note_index)
    );

    // A new run starts with an empty history and a zero score
    input_history u_input_history (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .clear        (start),
        .scan         (scan),
        .user_in      (user_in),
        .note_history (note_history)
    );

    score_judge u_score_judge (
        .prog_clk     (prog_clk),
        .rst          (rst),
        .clear        (start),
        .scan         (scan),
        .cur_note     (cur_note),
        .user_in      (user_in),
        .note_history (note_history),
        .score        (score)
    );

    tone_gen u_tone_gen (
        .prog_clk (prog_clk),
        .rst      (rst),
        .note     (cur_note),
        .sig      (sig)
    );

endmodule

`default_nettype wire

/* hdl/tone_gen.sv */
`default_nettype none

`include "chart_defines.svh"

module tone_gen import chart_pkg::*; (
    input  logic  prog_clk,
    input  logic  rst,
    input  note_t note,
    output logic  sig
);

    half_period_t half_period;
    half_period_t cnt;
    note_t        note_q;

    always_comb begin
        case (note)
            9'b01_0000001: half_period = half_period_t'(`HP_LOW_C);
            9'b01_0000010: half_period = half_period_t'(`HP_LOW_D);
            9'b01_0000100: half_period = half_period_t'(`HP_LOW_E);
            9'b01_0001000: half_period = half_period_t'(`HP_LOW_F);
            9'b01_0010000: half_period = half_period_t'(`HP_LOW_G);
            9'b01_0100000: half_period = half_period_t'(`HP_LOW_A);
            9'b01_1000000: half_period = half_period_t'(`HP_LOW_B);
            9'b00_0000001: half_period = half_period_t'(`HP_MID_C);
            9'b00_0000010: half_period = half_period_t'(`HP_MID_D);
            9'b00_0000100: half_period = half_period_t'(`HP_MID_E);
            9'b00_0001000: half_period = half_period_t'(`HP_MID_F);
            9'b00_0010000: half_period = half_period_t'(`HP_MID_G);
            9'b00_0100000: half_period = half_period_t'(`HP_MID_A);
            9'b00_1000000: half_period = half_period_t'(`HP_MID_B);
            9'b10_0000001: half_period = half_period_t'(`HP_HIGH_C);
            9'b10_0000010: half_period = half_period_t'(`HP_HIGH_D);
            9'b10_0000100: half_period = half_period_t'(`HP_HIGH_E);
            9'b10_0001000: half_period = half_period_t'(`HP_HIGH_F);
            9'b10_0010000: half_period = half_period_t'(`HP_HIGH_G);
            9'b10_0100000: half_period = half_period_t'(`HP_HIGH_A);
            9'b10_1000000: half_period = half_period_t'(`HP_HIGH_B);
            default:       half_period = '0;
        endcase
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            note_q <= '0;
            sig    <= 1'b0;
        end else if (note != note_q || half_period == '0) begin
            // New note or rest, restart the wave low
            cnt    <= '0;
            note_q <= note;
            sig    <= 1'b0;
        end else if (cnt == half_period - 1'b1) begin
            cnt <= '0;
            sig <= ~sig;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* score/input_history.sv */
`default_nettype none

module input_history import chart_pkg::*; (
    input  logic          prog_clk,
    input  logic          rst,
    input  logic          clear,
    input  logic          scan,
    input  note_t         user_in,
    output note_history_t note_history
);

    note_t prev1;
    note_t prev2;
    note_t prev3;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            prev1 <= '0;
            prev2 <= '0;
            prev3 <= '0;
        end else if (clear) begin
            prev1 <= '0;
            prev2 <= '0;
            prev3 <= '0;
        end else if (scan) begin
            prev1 <= user_in;
            prev2 <= prev1;
            prev3 <= prev2;
        end
    end

    assign note_history.prev1 = prev1;
    assign note_history.prev2 = prev2;
    assign note_history.prev3 = prev3;

endmodule

`default_nettype wire

/* score/score_judge.sv */
`default_nettype none

`include "chart_defines.svh"

module score_judge import chart_pkg::*; (
    input  logic          prog_clk,
    input  logic          rst,
    input  logic          clear,
    input  logic          scan,
    input  note_t         cur_note,
    input  note_t         user_in,
    input  note_history_t note_history,
    output score_t        score
);

    score_t            pts;
    logic [`SCORE_W:0] sum;

    // Fewer points the further back the matching input lies
    always_comb begin
        pts = '0;
        if (cur_note != '0) begin
            if (cur_note == user_in || cur_note == note_history.prev1) begin
                pts = score_t'(`PTS_PERFECT);
            end else if (cur_note == note_history.prev2) begin
                pts = score_t'(`PTS_GREAT);
            end else if (cur_note == note_history.prev3) begin
                pts = score_t'(`PTS_GOOD);
            end
        end
    end

    assign sum = {1'b0, score} + {1'b0, pts};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
        end else if (clear) begin
            score <= '0;
        end else if (scan) begin
            // Saturate on carry out
            score <= sum[`SCORE_W] ? '1 : sum[`SCORE_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* tests/tb_chart_player.sv */
`default_nettype none

`include "chart_defines.svh"

module tb_chart_player import chart_pkg::*; ();

    typedef note_t chart_arr_t [`CHART_LEN];
    typedef note_t scan_arr_t [2*`CHART_LEN];

    // Four runs of 20 notes and one tone run of 32 notes, plus chart loads
    localparam int TIMEOUT_CYCLES = 4 * (`COUNT_STEPS + 20 + 2) * `STEP_CYCLES +
                                    (`COUNT_STEPS + 32 + 2) * `STEP_CYCLES + 3 * 20 + 32 + 200;
    localparam int SEED = 63602;

    logic        prog_clk;
    logic        rst;
    logic        start;
    chart_len_t  chart_len;
    chart_wr_t   chart_wr;
    note_t       user_in;
    note_t       cur_note;
    led_t        led;
    logic        sig;
    score_t      score;
    logic        playing;
    logic        done;
    chart_addr_t note_index;

    chart_arr_t chart;
    scan_arr_t  scan_in;
    int         errors;
    int         err_mark;
    int         tests_run;
    int         tests_failed;
    int         cycles;
    int         exp_score;
    int         play_cyc;
    int         run_len;
    logic       done_q;

    chart_player_top dut (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .start      (start),
        .chart_len  (chart_len),
        .chart_wr   (chart_wr),
        .user_in    (user_in),
        .cur_note   (cur_note),
        .led        (led),
        .sig        (sig),
        .score      (score),
        .playing    (playing),
        .done       (done),
        .note_index (note_index)
    );

    initial begin
        prog_clk = 1'b0;
        forever #4 prog_clk = ~prog_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge prog_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // C is on led[7], octave shift on led[0]
    function automatic led_t led_ref(input note_t n);
        return {n[0], n[1], n[2], n[3], n[4], n[5], n[6], n[8] ^ n[7]};
    endfunction

    function automatic int hp_ref(input note_t n);
        int mid;
        int hp;
        case (n[6:0])
            7'b0000001: mid = `HP_MID_C;
            7'b0000010: mid = `HP_MID_D;
            7'b0000100: mid = `HP_MID_E;
            7'b0001000: mid = `HP_MID_F;
            7'b0010000: mid = `HP_MID_G;
            7'b0100000: mid = `HP_MID_A;
            7'b1000000: mid = `HP_MID_B;
            default:    mid = 0;
        endcase
        case (n[8:7])
            2'b00:   hp = mid;
            2'b01:   hp = mid * 2;
            2'b10:   hp = mid / 2;
            default: hp = 0;
        endcase
        return hp;
    endfunction

    function automatic int score_ref(input chart_arr_t notes, input int len,
                                     input scan_arr_t ins);
        note_t h1;
        note_t h2;
        note_t h3;
        note_t nt;
        int    total;
        h1 = '0;
        h2 = '0;
        h3 = '0;
        total = 0;
        // Two scans per note and the history shifts after each judgement
        for (int j = 0; j < 2 * len; j++) begin
            nt = notes[j / 2];
            if (nt != '0) begin
                if (nt == ins[j] || nt == h1) begin
                    total += `PTS_PERFECT;
                end else if (nt == h2) begin
                    total += `PTS_GREAT;
                end else if (nt == h3) begin
                    total += `PTS_GOOD;
                end
            end
            if (total > (1 << `SCORE_W) - 1) begin
                total = (1 << `SCORE_W) - 1;
            end
            h3 = h2;
            h2 = h1;
            h1 = ins[j];
        end
        return total;
    endfunction

    function automatic note_t random_note();
        note_t n;
        int    oct;
        oct = $urandom % 3;
        n = '0;
        n[$urandom % 7] = 1'b1;
        n[8:7] = (oct == 0) ? 2'b00 : (oct == 1) ? 2'b01 : 2'b10;
        return n;
    endfunction

    // Checks every play cycle against the chart, and the final state at done
    always @(negedge prog_clk) begin
        if (done && !done_q) begin
            if (playing !== 1'b0 || cur_note !== '0 || led !== '0) begin
                $display("ERR %0t: at done playing %b note %h led %b, expected all zero",
                         $time, playing, cur_note, led);
                errors++;
            end
            if (play_cyc != run_len * `STEP_CYCLES) begin
                $display("ERR %0t: playing was high for %0d cycles, expected %0d",
                         $time, play_cyc, run_len * `STEP_CYCLES);
                errors++;
            end
            if (score !== exp_score) begin
                $display("ERR %0t: score %0d, expected %0d", $time, score, exp_score);
                errors++;
            end
        end
        if (playing) begin
            if (cur_note !== chart[play_cyc / `STEP_CYCLES] ||
                note_index !== play_cyc / `STEP_CYCLES) begin
                $display("ERR %0t: step %0d shows note %h index %0d, expected note %h",
                         $time, play_cyc / `STEP_CYCLES, cur_note, note_index,
                         chart[play_cyc / `STEP_CYCLES]);
                errors++;
            end
            if (led !== led_ref(chart[play_cyc / `STEP_CYCLES])) begin
                $display("ERR %0t: led %b, expected %b", $time, led,
                         led_ref(chart[play_cyc / `STEP_CYCLES]));
                errors++;
            end
            play_cyc++;
        end else begin
            play_cyc = 0;
        end
        done_q = done;
    end

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - err_mark);
        end else begin
            $display("Test %s: ok", name);
        end
        err_mark = errors;
    endtask

    task automatic load_chart(input int len);
        for (int i = 0; i < len; i++) begin
            chart_wr.valid = 1'b1;
            chart_wr.addr = chart_addr_t'(i);
            chart_wr.note = chart[i];
            @(negedge prog_clk);
        end
        chart_wr = '0;
    endtask

    task automatic random_chart(input int len);
        for (int i = 0; i < `CHART_LEN; i++) begin
            chart[i] = (i < len) ? random_note() : note_t'(0);
        end
    endtask

    task automatic pulse_start(input int len);
        int wait_cyc;
        chart_len = chart_len_t'(len);
        run_len = len;
        start = 1'b1;
        @(negedge prog_clk);
        start = 1'b0;
        if (score !== '0) begin
            $display("ERR %0t: score %0d not cleared by start", $time, score);
            errors++;
        end
        wait_cyc = 0;
        while (!playing) begin
            @(negedge prog_clk);
            wait_cyc++;
        end
        if (wait_cyc != `COUNT_STEPS * `STEP_CYCLES) begin
            $display("ERR %0t: countdown took %0d cycles, expected %0d",
                     $time, wait_cyc, `COUNT_STEPS * `STEP_CYCLES);
            errors++;
        end
    endtask

    // Input for scan j is held until the next scan
    task automatic run_chart(input int len);
        int c;
        pulse_start(len);
        c = 0;
        while (!done) begin
            if (c % `SCAN_CYCLES == 0) begin
                user_in = scan_in[c / `SCAN_CYCLES];
            end
            c++;
            @(negedge prog_clk);
        end
        user_in = '0;
        @(negedge prog_clk);
    endtask

    task automatic check_tone(input note_t nt, input int len_cycles);
        int   edges;
        int   last_edge;
        logic prev;
        edges = 0;
        last_edge = 0;
        // One cycle for the note change to force sig low
        @(negedge prog_clk);
        prev = sig;
        for (int c = 2; c < len_cycles; c++) begin
            @(negedge prog_clk);
            if (sig !== prev) begin
                if (edges > 0 && c - last_edge != hp_ref(nt)) begin
                    $display("ERR %0t: note %h sig edges %0d cycles apart, expected %0d",
                             $time, nt, c - last_edge, hp_ref(nt));
                    errors++;
                end
                edges++;
                last_edge = c;
            end
            prev = sig;
        end
        @(negedge prog_clk);
        if (edges < 3) begin
            $display("Too few sig edges (%0d) while note %h was held", edges, nt);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        start = 1'b0;
        chart_len = '0;
        chart_wr = '0;
        user_in = '0;
        errors = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        exp_score = 0;
        play_cyc = 0;
        run_len = 0;
        done_q = 1'b0;
        for (int i = 0; i < 2 * `CHART_LEN; i++) begin
            scan_in[i] = '0;
        end
        random_chart(0);
        repeat (4) @(negedge prog_clk);
        rst = 1'b0;
        @(negedge prog_clk);

        if (playing !== 1'b0 || done !== 1'b0 || led !== '0 || sig !== 1'b0 ||
            cur_note !== '0 || score !== '0) begin
            $display("ERR %0t: outputs not idle after reset", $time);
            errors++;
        end
        end_test("2 idle after reset");

        random_chart(20);
        load_chart(20);
        exp_score = score_ref(chart, 20, scan_in);
        run_chart(20);
        end_test("1 sequence and leds");

        for (int j = 0; j < 40; j++) begin
            scan_in[j] = chart[j / 2];
        end
        // Every note is hit perfectly at both of its scans
        exp_score = 2 * 20 * `PTS_PERFECT;
        run_chart(20);
        end_test("3 perfect play");

        // Late, rest and random inputs over two runs
        for (int r = 0; r < 2; r++) begin
            random_chart(20);
            load_chart(20);
            for (int j = 0; j < 40; j++) begin
                case ($urandom % 5)
                    0:       scan_in[j] = chart[j / 2];
                    1:       scan_in[j] = (j >= 2) ? chart[j / 2 - 1] : note_t'(0);
                    2:       scan_in[j] = (j >= 4) ? chart[j / 2 - 2] : note_t'(0);
                    3:       scan_in[j] = '0;
                    default: scan_in[j] = random_note();
                endcase
            end
            exp_score = score_ref(chart, 20, scan_in);
            run_chart(20);
        end
        end_test("4 late and random play");

        // Ten steps each of low A, middle E and high G, then two rest steps
        for (int i = 0; i < `CHART_LEN; i++) begin
            chart[i] = (i < 10) ? 9'b01_0100000 : (i < 20) ? 9'b00_0000100 :
                       (i < 30) ? 9'b10_0010000 : 9'b00_0000000;
        end
        for (int j = 0; j < 2 * `CHART_LEN; j++) begin
            scan_in[j] = '0;
        end
        load_chart(32);
        exp_score = score_ref(chart, 32, scan_in);
        pulse_start(32);
        for (int g = 0; g < 3; g++) begin
            check_tone(chart[g * 10], 10 * `STEP_CYCLES);
        end
        for (int c = 1; c < 2 * `STEP_CYCLES; c++) begin
            @(negedge prog_clk);
            if (sig !== 1'b0) begin
                $display("ERR %0t: sig high during a rest note", $time);
                errors++;
            end
        end
        while (!done) @(negedge prog_clk);
        @(negedge prog_clk);
        end_test("5 tone");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
